//--- design/bus_pkg.sv
// One request in flight at a time; a wstrb of all zero marks a read
package bus_pkg;

	// Byte address and data word
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// Byte write strobes
	typedef logic [3:0] strb_t;

	// Block RAM word index wide enough for 2048 words
	typedef logic [10:0] word_idx_t;

	// Master holds all fields until ready
	typedef struct packed {
		logic  valid;
		addr_t addr;
		data_t wdata;
		strb_t wstrb;
	} mem_req_t;

	// ready pulses for one cycle and rdata is valid only then
	typedef struct packed {
		logic  ready;
		data_t rdata;
	} mem_rsp_t;

	typedef enum logic [1:0] {
		REGION_RAM,
		REGION_PERIPH,
		REGION_NONE
	} region_e;

	// Upper address nibble of the peripheral window
	localparam logic [3:0] PERIPH_BASE = 4'hF;

endpackage

//--- design/periph_pkg.sv
// Register offsets are 16-bit offsets within the peripheral window; UART is 8N1 only
package periph_pkg;

	// Register map
	localparam logic [15:0] OFS_UART_DATA = 16'h0000;
	localparam logic [15:0] OFS_UART_STAT = 16'h0004;
	localparam logic [15:0] OFS_LED       = 16'h1000;
	localparam logic [15:0] OFS_SECS      = 16'h1100;

	// Status register bits
	localparam int STAT_DR_BIT     = 0;
	localparam int STAT_TXBUSY_BIT = 1;

	typedef logic [7:0]  byte_t;
	typedef logic [31:0] secs_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} uart_tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} uart_rx_state_e;

endpackage

//--- design/uart_core.sv
// 8N1 only, no parity or break detection; a frame with a low stop bit is dropped
`timescale 1ns/1ps

module uart_core #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic              clk,
	input  logic              resetn,
	input  logic              tx_start_i,
	input  periph_pkg::byte_t tx_byte_i,
	output logic              tx_active_o,
	input  logic              rx_i,
	output logic              rx_valid_o,
	output periph_pkg::byte_t rx_byte_o,
	output logic              tx_o
);

	localparam int CW = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);
	localparam logic [CW-1:0] BIT_HALF = CW'((CLKS_PER_BIT - 1) / 2);

	periph_pkg::uart_tx_state_e tx_state;
	logic [CW-1:0]              tx_cnt;
	logic [2:0]                 tx_bit;
	periph_pkg::byte_t          tx_shift;
	logic                       tx_q;

	periph_pkg::uart_rx_state_e rx_state;
	logic [CW-1:0]              rx_cnt;
	logic [2:0]                 rx_bit;
	periph_pkg::byte_t          rx_shift;
	periph_pkg::byte_t          rx_byte_q;
	logic [1:0]                 rx_sync;
	logic                       rx_d;
	logic                       rx_valid_q;

	assign rx_d = rx_sync[1];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			tx_state <= periph_pkg::TX_IDLE;
			tx_cnt <= '0;
			tx_bit <= '0;
			tx_q <= 1'b1;
		end else begin
			case (tx_state)
				periph_pkg::TX_IDLE: begin
					if (tx_start_i) begin
						tx_state <= periph_pkg::TX_START;
						tx_cnt <= '0;
						tx_q <= 1'b0;
					end
				end
				periph_pkg::TX_START: begin
					tx_cnt <= tx_cnt + 1'b1;
					if (tx_cnt == BIT_LAST) begin
						tx_state <= periph_pkg::TX_DATA;
						tx_cnt <= '0;
						tx_bit <= '0;
						tx_q <= tx_shift[0];
					end
				end
				periph_pkg::TX_DATA: begin
					tx_cnt <= tx_cnt + 1'b1;
					if (tx_cnt == BIT_LAST) begin
						tx_cnt <= '0;
						if (tx_bit == 3'd7) begin
							tx_state <= periph_pkg::TX_STOP;
							tx_q <= 1'b1;
						end else begin
							tx_bit <= tx_bit + 3'd1;
							tx_q <= tx_shift[tx_bit + 3'd1];
						end
					end
				end
				default: begin
					tx_cnt <= tx_cnt + 1'b1;
					if (tx_cnt == BIT_LAST) begin
						tx_state <= periph_pkg::TX_IDLE;
						tx_cnt <= '0;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			rx_sync <= 2'b11;
			rx_state <= periph_pkg::RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_valid_q <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx_i};
			rx_valid_q <= 1'b0;
			case (rx_state)
				periph_pkg::RX_IDLE: begin
					rx_cnt <= '0;
					if (!rx_d)
						rx_state <= periph_pkg::RX_START;
				end
				periph_pkg::RX_START: begin
					rx_cnt <= rx_cnt + 1'b1;
					// Start bit must still be low at mid-bit to count as a frame
					if (rx_cnt == BIT_HALF) begin
						rx_cnt <= '0;
						rx_bit <= '0;
						rx_state <= rx_d ? periph_pkg::RX_IDLE : periph_pkg::RX_DATA;
					end
				end
				periph_pkg::RX_DATA: begin
					rx_cnt <= rx_cnt + 1'b1;
					if (rx_cnt == BIT_LAST) begin
						rx_cnt <= '0;
						rx_bit <= rx_bit + 3'd1;
						if (rx_bit == 3'd7)
							rx_state <= periph_pkg::RX_STOP;
					end
				end
				default: begin
					rx_cnt <= rx_cnt + 1'b1;
					if (rx_cnt == BIT_LAST) begin
						rx_state <= periph_pkg::RX_IDLE;
						rx_valid_q <= rx_d;
					end
				end
			endcase
		end
	end

	// Shift registers and the received byte
	always_ff @(posedge clk) begin
		if (tx_state == periph_pkg::TX_IDLE && tx_start_i)
			tx_shift <= tx_byte_i;
		if (rx_state == periph_pkg::RX_DATA && rx_cnt == BIT_LAST)
			rx_shift <= {rx_d, rx_shift[7:1]};
		if (rx_state == periph_pkg::RX_STOP && rx_cnt == BIT_LAST && rx_d)
			rx_byte_q <= rx_shift;
	end

	assign tx_o = tx_q;
	assign tx_active_o = (tx_state != periph_pkg::TX_IDLE);
	assign rx_valid_o = rx_valid_q;
	assign rx_byte_o = rx_byte_q;

	a_no_start_busy: assert property (@(posedge clk) disable iff (!resetn)
		tx_start_i |-> !tx_active_o);

endmodule

//--- design/bram_store.sv
// No initial contents; a write returns the word as it was before the write
`timescale 1ns/1ps

module bram_store #(
	parameter int BRAM_WORDS = 1536
) (
	input  logic              clk,
	input  logic              resetn,
	input  bus_pkg::mem_req_t req_i,
	output bus_pkg::mem_rsp_t rsp_o
);

	localparam int IW = $bits(bus_pkg::word_idx_t);

	bus_pkg::data_t     mem [BRAM_WORDS];
	bus_pkg::word_idx_t idx;
	logic               ready_q;
	bus_pkg::data_t     rdata_q;

	assign idx = req_i.addr[IW+1:2];

	always_ff @(posedge clk) begin
		if (!resetn)
			ready_q <= 1'b0;
		else
			ready_q <= req_i.valid;
	end

	// Old word is read out while strobed byte lanes are written
	always_ff @(posedge clk) begin
		if (req_i.valid) begin
			rdata_q <= mem[idx];
			for (int b = 0; b < 4; b++) begin
				if (req_i.wstrb[b])
					mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
			end
		end
	end

	assign rsp_o.ready = ready_q;
	assign rsp_o.rdata = rdata_q;

	// decoder must keep accesses inside the array
	a_idx_range: assert property (@(posedge clk) disable iff (!resetn)
		req_i.valid |-> (int'(idx) < BRAM_WORDS));

endmodule

//--- design/mem_decode.sv
// Master must hold the request until ready; unmapped accesses complete with zero data
`timescale 1ns/1ps

module mem_decode #(
	parameter int BRAM_WORDS = 1536
) (
	input  logic              clk,
	input  logic              resetn,
	input  bus_pkg::mem_req_t host_req_i,
	output bus_pkg::mem_rsp_t host_rsp_o,
	output bus_pkg::mem_req_t ram_req_o,
	input  bus_pkg::mem_rsp_t ram_rsp_i,
	output bus_pkg::mem_req_t reg_req_o,
	input  bus_pkg::mem_rsp_t reg_rsp_i
);

	localparam bus_pkg::addr_t RAM_LIMIT = bus_pkg::addr_t'(BRAM_WORDS * 4);

	bus_pkg::region_e region;
	logic             live;
	logic             none_ready;

	always_comb begin
		if (host_req_i.addr < RAM_LIMIT)
			region = bus_pkg::REGION_RAM;
		else if (host_req_i.addr[31:28] == bus_pkg::PERIPH_BASE)
			region = bus_pkg::REGION_PERIPH;
		else
			region = bus_pkg::REGION_NONE;
	end

	// Request stays visible during its ready cycle, so mask it there
	assign live = host_req_i.valid && !host_rsp_o.ready;

	always_comb begin
		ram_req_o       = host_req_i;
		ram_req_o.valid = live && (region == bus_pkg::REGION_RAM);

		reg_req_o       = host_req_i;
		reg_req_o.valid = live && (region == bus_pkg::REGION_PERIPH);
		reg_req_o.addr  = {16'h0000, host_req_i.addr[15:0]};
	end

	// Default completion for unmapped space
	always_ff @(posedge clk) begin
		if (!resetn)
			none_ready <= 1'b0;
		else
			none_ready <= live && (region == bus_pkg::REGION_NONE);
	end

	// Address is still held, so region still names the answering target
	always_comb begin
		case (region)
			bus_pkg::REGION_RAM:    host_rsp_o = ram_rsp_i;
			bus_pkg::REGION_PERIPH: host_rsp_o = reg_rsp_i;
			default: begin
				host_rsp_o.ready = none_ready;
				host_rsp_o.rdata = '0;
			end
		endcase
	end

	a_ready_single: assert property (@(posedge clk) disable iff (!resetn)
		host_rsp_o.ready |=> !host_rsp_o.ready);

endmodule

//--- design/sysctl_regs.sv
// Data writes stall while txbusy is set; seconds count wraps after 2^32 seconds
`timescale 1ns/1ps

module sysctl_regs #(
	parameter int CLKS_PER_BIT  = 16,
	parameter int TICKS_PER_SEC = 200
) (
	input  logic              clk,
	input  logic              resetn,
	input  bus_pkg::mem_req_t req_i,
	output bus_pkg::mem_rsp_t rsp_o,
	input  logic              uart_rx_i,
	output logic              uart_tx_o,
	input  logic              uart_rts_i,
	output logic              uart_cts_o,
	output logic              led_o
);

	localparam int PW = $clog2(TICKS_PER_SEC + 1);

	logic [15:0]       off;
	logic              is_write;
	logic              data_wr;
	logic              data_rd;
	logic              accept;
	bus_pkg::data_t    rd_word;

	logic              ready_q;
	bus_pkg::data_t    rdata_q;
	logic              tx_start_q;
	periph_pkg::byte_t tx_byte_q;
	logic              txbusy_q;
	logic              dr_q;
	logic              cts_q;
	logic              led_q;
	logic [PW-1:0]     tick_cnt;
	periph_pkg::secs_t secs_q;

	logic              tx_active;
	logic              rx_valid;
	periph_pkg::byte_t rx_byte;

	assign off = req_i.addr[15:0];
	assign is_write = |req_i.wstrb;
	assign data_wr = req_i.valid && is_write && (off == periph_pkg::OFS_UART_DATA);
	assign data_rd = req_i.valid && !is_write && (off == periph_pkg::OFS_UART_DATA);
	// Back-pressure only on a data write while busy
	assign accept = req_i.valid && !(data_wr && txbusy_q);

	always_comb begin
		rd_word = '0;
		case (off)
			periph_pkg::OFS_UART_DATA: rd_word[7:0] = rx_byte;
			periph_pkg::OFS_UART_STAT: begin
				rd_word[periph_pkg::STAT_DR_BIT] = dr_q;
				rd_word[periph_pkg::STAT_TXBUSY_BIT] = txbusy_q;
			end
			periph_pkg::OFS_LED:  rd_word[0] = ~led_q;
			periph_pkg::OFS_SECS: rd_word = secs_q;
			default: rd_word = '0;
		endcase
		if (is_write)
			rd_word = '0;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ready_q <= 1'b0;
			tx_start_q <= 1'b0;
			txbusy_q <= 1'b0;
			dr_q <= 1'b0;
			cts_q <= 1'b0;
			led_q <= 1'b1;
		end else begin
			ready_q <= accept;
			tx_start_q <= data_wr && !txbusy_q;

			// Host may only send again once RTS is released
			if (!tx_start_q && !tx_active && !uart_rts_i)
				txbusy_q <= 1'b0;
			if (data_wr && !txbusy_q)
				txbusy_q <= 1'b1;

			if (data_rd) begin
				dr_q <= 1'b0;
				cts_q <= 1'b0;
			end
			if (rx_valid) begin
				dr_q <= 1'b1;
				cts_q <= 1'b1;
			end

			if (accept && is_write && off == periph_pkg::OFS_LED)
				led_q <= ~req_i.wdata[0];
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			rdata_q <= rd_word;
		if (data_wr && !txbusy_q)
			tx_byte_q <= req_i.wdata[7:0];
	end

	// Seconds prescaler
	always_ff @(posedge clk) begin
		if (!resetn) begin
			tick_cnt <= '0;
			secs_q <= '0;
		end else if (tick_cnt == PW'(TICKS_PER_SEC - 1)) begin
			tick_cnt <= '0;
			secs_q <= secs_q + 1'b1;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	uart_core #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_uart0 (
		.clk        (clk),
		.resetn     (resetn),
		.tx_start_i (tx_start_q),
		.tx_byte_i  (tx_byte_q),
		.tx_active_o(tx_active),
		.rx_i       (uart_rx_i),
		.rx_valid_o (rx_valid),
		.rx_byte_o  (rx_byte),
		.tx_o       (uart_tx_o)
	);

	assign rsp_o.ready = ready_q;
	assign rsp_o.rdata = rdata_q;
	assign uart_cts_o = cts_q;
	assign led_o = led_q;

	// A pending start or a frame on the line keeps txbusy set
	a_no_wr_while_busy: assert property (@(posedge clk) disable iff (!resetn)
		(tx_start_q || tx_active) |-> txbusy_q);

endmodule

//--- design/sysctl_top.sv
// Single clock domain; RAM contents are undefined after power-up and no firmware is loaded
`timescale 1ns/1ps

module sysctl_top #(
	parameter int BRAM_WORDS    = 1536,
	parameter int CLKS_PER_BIT  = 16,
	parameter int TICKS_PER_SEC = 200
) (
	input  logic              clk,
	input  logic              resetn,
	input  bus_pkg::mem_req_t mem_req_i,
	output bus_pkg::mem_rsp_t mem_rsp_o,
	input  logic              uart_rx_i,
	output logic              uart_tx_o,
	input  logic              uart_rts_i,
	output logic              uart_cts_o,
	output logic              led_o
);

	bus_pkg::mem_req_t ram_req;
	bus_pkg::mem_rsp_t ram_rsp;
	bus_pkg::mem_req_t reg_req;
	bus_pkg::mem_rsp_t reg_rsp;

	mem_decode #(
		.BRAM_WORDS(BRAM_WORDS)
	) u_decode (
		.clk       (clk),
		.resetn    (resetn),
		.host_req_i(mem_req_i),
		.host_rsp_o(mem_rsp_o),
		.ram_req_o (ram_req),
		.ram_rsp_i (ram_rsp),
		.reg_req_o (reg_req),
		.reg_rsp_i (reg_rsp)
	);

	bram_store #(
		.BRAM_WORDS(BRAM_WORDS)
	) u_bram (
		.clk   (clk),
		.resetn(resetn),
		.req_i (ram_req),
		.rsp_o (ram_rsp)
	);

	sysctl_regs #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.TICKS_PER_SEC(TICKS_PER_SEC)
	) u_regs (
		.clk       (clk),
		.resetn    (resetn),
		.req_i     (reg_req),
		.rsp_o     (reg_rsp),
		.uart_rx_i (uart_rx_i),
		.uart_tx_o (uart_tx_o),
		.uart_rts_i(uart_rts_i),
		.uart_cts_o(uart_cts_o),
		.led_o     (led_o)
	);

endmodule

//--- dv/tb_checker.sv
// Bus reads are checked only where the model knows the value; RAM bytes never written are skipped
`timescale 1ns/1ps

module tb_checker #(
	parameter int BRAM_WORDS    = 1536,
	parameter int CLKS_PER_BIT  = 16,
	parameter int TICKS_PER_SEC = 200
) (
	input  logic              clk,
	input  logic              resetn,
	input  bus_pkg::mem_req_t mem_req_i,
	input  bus_pkg::mem_rsp_t mem_rsp_i,
	input  logic              uart_tx_i,
	input  logic              uart_rx_i,
	input  logic              uart_rts_i,
	input  logic              uart_cts_i,
	input  logic              led_i,
	output int                err_cnt,
	output int                chk_cnt
);

	bus_pkg::data_t ram_m [BRAM_WORDS];
	logic [3:0]     known_m [BRAM_WORDS];
	logic [7:0]     tx_exp_q [$];
	logic           tx_pending;
	logic           tx_done;
	logic           dr_m;
	logic [7:0]     last_rx_m;
	logic           led_bit_m;
	longint         cyc;
	longint         prev_cyc;
	longint         prev_secs;
	logic           have_prev;

	initial begin
		err_cnt = 0;
		chk_cnt = 0;
		tx_pending = 1'b0;
		tx_done = 1'b0;
		dr_m = 1'b0;
		led_bit_m = 1'b0;
		cyc = 0;
		have_prev = 1'b0;
		for (int i = 0; i < BRAM_WORDS; i++)
			known_m[i] = 4'h0;
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	function automatic logic busy_model();
		return tx_pending && !(tx_done && !uart_rts_i);
	endfunction

	always @(posedge clk) begin
		if (resetn)
			cyc++;
	end

	task automatic handle_secs(input logic [31:0] act);
		longint exp;
		longint dexp;
		exp = cyc / TICKS_PER_SEC;
		chk_cnt++;
		if (act > exp + 1 || act + 1 < exp) begin
			err_cnt++;
			$display("ERR secs expected %0d actual %0d", exp, act);
		end
		if (have_prev) begin
			dexp = (cyc - prev_cyc) / TICKS_PER_SEC;
			chk_cnt++;
			if (act - prev_secs > dexp + 1 || act - prev_secs + 1 < dexp) begin
				err_cnt++;
				$display("ERR secs_delta expected %0d actual %0d", dexp, act - prev_secs);
			end
		end
		have_prev = 1'b1;
		prev_cyc = cyc;
		prev_secs = act;
	endtask

	task automatic handle_rsp();
		bus_pkg::addr_t a;
		bus_pkg::data_t d;
		bus_pkg::data_t r;
		bus_pkg::data_t mask;
		logic           wr;
		int             w;
		a = mem_req_i.addr;
		d = mem_req_i.wdata;
		r = mem_rsp_i.rdata;
		wr = |mem_req_i.wstrb;
		if (a < 32'(BRAM_WORDS * 4)) begin
			w = int'(a[31:2]);
			if (wr) begin
				for (int b = 0; b < 4; b++) begin
					if (mem_req_i.wstrb[b]) begin
						ram_m[w][8*b +: 8] = d[8*b +: 8];
						known_m[w][b] = 1'b1;
					end
				end
			end else if (known_m[w] != 4'h0) begin
				for (int b = 0; b < 4; b++)
					mask[8*b +: 8] = {8{known_m[w][b]}};
				check_val("ram_read", ram_m[w] & mask, r & mask);
			end
		end else if (a[31:28] == 4'hF) begin
			case (a[15:0])
				16'h0000: begin
					if (wr) begin
						// Completion while busy means the stall failed
						check_val("uart_backpressure", 32'd0, {31'd0, busy_model()});
						tx_exp_q.push_back(d[7:0]);
						tx_pending = 1'b1;
						tx_done = 1'b0;
					end else begin
						check_val("uart_rx_data", {24'd0, last_rx_m}, r);
						dr_m = 1'b0;
					end
				end
				16'h0004: begin
					if (!wr) begin
						check_val("uart_status", {30'd0, busy_model(), dr_m}, r);
						check_val("uart_cts", {31'd0, dr_m}, {31'd0, uart_cts_i});
					end
				end
				16'h1000: begin
					if (wr)
						led_bit_m = d[0];
					else
						check_val("led_read", {31'd0, led_bit_m}, r);
				end
				16'h1100: begin
					if (!wr)
						handle_secs(r);
				end
				default: begin
					if (!wr)
						check_val("reserved_read", 32'd0, r);
				end
			endcase
		end else if (!wr) begin
			check_val("unmapped_read", 32'd0, r);
		end
	endtask

	always @(negedge clk) begin
		if (resetn) begin
			if (mem_rsp_i.ready)
				handle_rsp();
			check_val("led_pin", {31'd0, ~led_bit_m}, {31'd0, led_i});
		end
	end

	// Decodes the transmit line at mid-bit
	initial begin
		logic [7:0] byte_v;
		forever begin
			@(negedge uart_tx_i);
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			check_val("uart_tx_start", 32'd0, {31'd0, uart_tx_i});
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				byte_v[i] = uart_tx_i;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			check_val("uart_tx_stop", 32'd1, {31'd0, uart_tx_i});
			if (tx_exp_q.size() == 0) begin
				err_cnt++;
				$display("UART transmitted a frame that no data write requested");
			end else begin
				check_val("uart_tx_byte", {24'd0, tx_exp_q.pop_front()}, {24'd0, byte_v});
			end
			tx_done = 1'b1;
		end
	end

	// Receive line decoder
	initial begin
		logic [7:0] byte_v;
		forever begin
			@(negedge uart_rx_i);
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				byte_v[i] = uart_rx_i;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			last_rx_m = byte_v;
			dr_m = 1'b1;
		end
	end

endmodule

//--- dv/tb_top.sv
// Random bus traffic from a fixed seed; UART frames are timed at CLKS_PER_BIT clocks per bit
`timescale 1ns/1ps

module tb_top;

	localparam int BRAM_WORDS    = 1536;
	localparam int CLKS_PER_BIT  = 16;
	localparam int TICKS_PER_SEC = 200;
	localparam int N_RAM         = 64;
	localparam int N_ODD         = 24;
	localparam int SEC_GAP       = 3;
	localparam int FRAME_CLKS    = 10 * CLKS_PER_BIT;
	localparam int NUM_REQ       = 2 * N_RAM + 3 * N_ODD + 30;
	localparam int REQ_BOUND     = 8;
	localparam int WATCHDOG      = 2 * (NUM_REQ * REQ_BOUND + 3 * (FRAME_CLKS + 250)
		+ (SEC_GAP + 2) * TICKS_PER_SEC);

	logic              clk;
	logic              resetn;
	bus_pkg::mem_req_t mem_req;
	bus_pkg::mem_rsp_t mem_rsp;
	logic              uart_rx;
	logic              uart_tx;
	logic              uart_rts;
	logic              uart_cts;
	logic              led;
	int                err_cnt;
	int                chk_cnt;
	int                seed;
	int                ram_words [$];

	sysctl_top #(
		.BRAM_WORDS   (BRAM_WORDS),
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.TICKS_PER_SEC(TICKS_PER_SEC)
	) u_dut (
		.clk       (clk),
		.resetn    (resetn),
		.mem_req_i (mem_req),
		.mem_rsp_o (mem_rsp),
		.uart_rx_i (uart_rx),
		.uart_tx_o (uart_tx),
		.uart_rts_i(uart_rts),
		.uart_cts_o(uart_cts),
		.led_o     (led)
	);

	tb_checker #(
		.BRAM_WORDS   (BRAM_WORDS),
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.TICKS_PER_SEC(TICKS_PER_SEC)
	) u_chk (
		.clk       (clk),
		.resetn    (resetn),
		.mem_req_i (mem_req),
		.mem_rsp_i (mem_rsp),
		.uart_tx_i (uart_tx),
		.uart_rx_i (uart_rx),
		.uart_rts_i(uart_rts),
		.uart_cts_i(uart_cts),
		.led_i     (led),
		.err_cnt   (err_cnt),
		.chk_cnt   (chk_cnt)
	);

	always #50 clk = ~clk;

	// Issues one request and holds it until ready is seen
	task automatic bus_access(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
		mem_req.valid = 1'b1;
		mem_req.addr = a;
		mem_req.wdata = d;
		mem_req.wstrb = s;
		do
			@(negedge clk);
		while (!mem_rsp.ready);
		@(posedge clk);
		#1;
		mem_req.valid = 1'b0;
	endtask

	task automatic send_rx_frame(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx = frame[i];
			repeat (CLKS_PER_BIT) @(posedge clk);
			#1;
		end
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		mem_req = '0;
		uart_rx = 1'b1;
		uart_rts = 1'b0;
		seed = 32'h2f130360;
		repeat (8) @(posedge clk);
		#1;
		resetn = 1'b1;

		for (int i = 0; i < N_RAM; i++) begin
			ram_words.push_back(int'($unsigned($random(seed)) % BRAM_WORDS));
			bus_access(32'(ram_words[i] * 4), $random(seed), 4'($random(seed)));
		end
		for (int i = 0; i < N_ODD; i++) begin
			bus_access(32'h0000_2000 | ($random(seed) & 32'h7fff_fffc), $random(seed),
				4'($random(seed)) | 4'h1);
			bus_access(32'hF000_2008 | ($random(seed) & 32'h0000_0ef0), $random(seed), 4'h0);
			bus_access(32'h0000_4000 | ($random(seed) & 32'h3fff_fffc), 32'd0, 4'h0);
		end
		for (int i = 0; i < N_RAM; i++)
			bus_access(32'(ram_words[($unsigned($random(seed))) % N_RAM] * 4), 32'd0, 4'h0);

		// Transmit with RTS held, then release it under a stalled write
		uart_rts = 1'b1;
		bus_access(32'hF000_0000, $random(seed), 4'hF);
		repeat (FRAME_CLKS + 20) @(posedge clk);
		#1;
		bus_access(32'hF000_0004, 32'd0, 4'h0);
		fork
			bus_access(32'hF000_0000, $random(seed), 4'h1);
			begin
				repeat (40) @(posedge clk);
				#1;
				uart_rts = 1'b0;
			end
		join
		repeat (FRAME_CLKS + 40) @(posedge clk);
		#1;
		bus_access(32'hF000_0004, 32'd0, 4'h0);

		send_rx_frame(8'($random(seed)));
		repeat (20) @(posedge clk);
		#1;
		bus_access(32'hF000_0004, 32'd0, 4'h0);
		bus_access(32'hF000_0000, 32'd0, 4'h0);
		bus_access(32'hF000_0004, 32'd0, 4'h0);

		for (int i = 0; i < 4; i++) begin
			bus_access(32'hF000_1000, $random(seed), 4'hF);
			bus_access(32'hF000_1000, 32'd0, 4'h0);
		end

		bus_access(32'hF000_1100, 32'd0, 4'h0);
		repeat (SEC_GAP * TICKS_PER_SEC) @(posedge clk);
		#1;
		bus_access(32'hF000_1100, 32'd0, 4'h0);

		repeat (10) @(posedge clk);
		$display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
		if (err_cnt == 0 && chk_cnt > 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#1;
		repeat (WATCHDOG) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- flist.f
design/bus_pkg.sv
design/periph_pkg.sv
design/uart_core.sv
design/bram_store.sv
design/mem_decode.sv
design/sysctl_regs.sv
design/sysctl_top.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top -f flist.f --Mdir obj_dir -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
	exit 0
fi
exit 1
